/* rtl/vlane_cfg_pkg.sv */
`default_nettype none

package vlane_cfg_pkg;

    ////////////////////////////////////////////////////////////
    // Lane array and VRF geometry
    ////////////////////////////////////////////////////////////
    localparam int VLANE_NUM       = 8;
    localparam int MEM_DEPTH       = 512;  // Words per lane
    localparam int MAX_VL_PER_LANE = 256;
    localparam int R_PORTS_NUM     = 8;    // Read ports feeding the muxes
    localparam int ALU_OPMODE_W    = 6;

    ////////////////////////////////////////////////////////////
    // Width types
    ////////////////////////////////////////////////////////////
    typedef logic [$clog2(MEM_DEPTH)-1:0]                   vrf_addr_t;
    typedef logic [$clog2(VLANE_NUM*MAX_VL_PER_LANE)-1:0]   vl_t;
    // Extra bit so a full lane count fits
    typedef logic [$clog2(MAX_VL_PER_LANE):0]               lane_cnt_t;
    typedef logic [$clog2(R_PORTS_NUM)-1:0]                 port_sel_t;
    typedef logic [3:0]                                     bwen_t;
    typedef bwen_t [VLANE_NUM-1:0]                          lane_bwen_t;
    typedef vrf_addr_t [VLANE_NUM-1:0]                      lane_addr_t;
    typedef logic [1:0]                                     el_width_t;
    typedef logic [31:0]                                    word_t;

    // Element width codes
    localparam el_width_t EW_NONE = 2'd0;
    localparam el_width_t EW_BYTE = 2'd1;
    localparam el_width_t EW_HALF = 2'd2;
    localparam el_width_t EW_WORD = 2'd3;

endpackage

`default_nettype wire

/* rtl/driver_ctrl_pkg.sv */
`default_nettype none

package driver_ctrl_pkg;

    ////////////////////////////////////////////////////////////
    // Instruction and state encodings
    ////////////////////////////////////////////////////////////
    // Codes 1 and 6 stay reserved
    typedef enum logic [2:0] {
        NORMAL        = 3'd0,
        STORE         = 3'd2,
        INDEXED_STORE = 3'd3,
        LOAD          = 3'd4,
        INDEXED_LOAD  = 3'd5
    } inst_type_e;

    typedef enum logic [1:0] {
        IDLE,
        NORMAL_MODE,  // Read, compute, write back
        READ_MODE,    // Stores and indexed load
        LOAD_MODE
    } drv_state_e;

    ////////////////////////////////////////////////////////////
    // Side-band bundles
    ////////////////////////////////////////////////////////////
    typedef struct packed {
        logic [1:0]                              op2_sel;
        vlane_cfg_pkg::port_sel_t                op3_sel;
        vlane_cfg_pkg::word_t                    x_data;   // Scalar operand
        logic [4:0]                              imm;
        logic [vlane_cfg_pkg::ALU_OPMODE_W-1:0]  opmode;
        logic                                    en_32bit_mul;
        logic                                    vector_mask;
    } alu_ctrl_t;

    typedef struct packed {
        vlane_cfg_pkg::port_sel_t  data_mux_sel;
        vlane_cfg_pkg::port_sel_t  index_mux_sel;
        logic                      data_valid;
        logic                      index_valid;
    } store_ctrl_t;

    // FSM to write port
    typedef struct packed {
        logic                      load_addr;   // Strobe to restart at start_addr
        vlane_cfg_pkg::vrf_addr_t  start_addr;
        logic                      advance;     // Strobe for one beat
        vlane_cfg_pkg::el_width_t  width;
        logic                      bwen_en;
        logic                      load_mode;   // Take lane bwen from load source
    } wr_ctrl_t;

endpackage

`default_nettype wire

/* rtl/vrf_addr_counter.sv */
`default_nettype none

module vrf_addr_counter (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  logic                      load_i,
    input  vlane_cfg_pkg::vrf_addr_t  start_addr_i,
    input  logic                      advance_i,
    input  vlane_cfg_pkg::el_width_t  width_i,
    output vlane_cfg_pkg::vrf_addr_t  addr_o,
    output logic [1:0]                beat_o
);
    import vlane_cfg_pkg::*;

    logic [1:0] last_beat;
    logic       wrap;

    // Beats packed into one VRF word
    always_comb begin
        case (width_i)
            EW_BYTE: last_beat = 2'd3;
            EW_HALF: last_beat = 2'd1;
            default: last_beat = 2'd0;  // Word steps every beat
        endcase
    end

    assign wrap = (beat_o == last_beat);

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            addr_o <= '0;
            beat_o <= '0;
        end else if (load_i) begin
            addr_o <= start_addr_i;
            beat_o <= '0;
        end else if (advance_i) begin
            if (wrap) begin
                beat_o <= '0;
                addr_o <= addr_o + 1'b1;  // Word full
            end else begin
                beat_o <= beat_o + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/vrf_write_port.sv */
`default_nettype none

module vrf_write_port (
    input  logic                       clk_i,
    input  logic                       rst_i,
    input  driver_ctrl_pkg::wr_ctrl_t  wr_i,
    input  vlane_cfg_pkg::lane_bwen_t  load_bwen_i,
    output vlane_cfg_pkg::lane_addr_t  waddr_o,
    output vlane_cfg_pkg::lane_bwen_t  bwen_o
);
    import vlane_cfg_pkg::*;

    vrf_addr_t  waddr;
    logic [1:0] beat;
    bwen_t      pattern;

    vrf_addr_counter u_waddr_cnt (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .load_i       (wr_i.load_addr),
        .start_addr_i (wr_i.start_addr),
        .advance_i    (wr_i.advance),
        .width_i      (wr_i.width),
        .addr_o       (waddr),
        .beat_o       (beat)
    );

    ////////////////////////////////////////////////////////////
    // Byte enable pattern from the beat position
    ////////////////////////////////////////////////////////////
    always_comb begin
        pattern = '0;
        if (wr_i.bwen_en) begin
            case (wr_i.width)
                EW_BYTE: pattern = bwen_t'(4'b0001 << beat);
                EW_HALF: pattern = beat[0] ? 4'b1100 : 4'b0011;
                EW_WORD: pattern = 4'b1111;
                EW_NONE: pattern = '0;
                default: pattern = '0;
            endcase
        end
    end

    // Same address and pattern in every lane
    always_comb begin
        for (int lane = 0; lane < VLANE_NUM; lane++) begin
            waddr_o[lane] = waddr;
            if (wr_i.load_mode) begin
                bwen_o[lane] = load_bwen_i[lane];  // Load source decides per lane
            end else begin
                bwen_o[lane] = pattern;
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/driver_fsm.sv */
`default_nettype none

module driver_fsm (
    input  logic                            clk_i,
    input  logic                            rst_i,
    // Handshake
    input  logic                            start_i,
    output logic                            ready_o,
    // Instruction fields
    input  driver_ctrl_pkg::inst_type_e     inst_type_i,
    input  vlane_cfg_pkg::vl_t              vl_i,
    input  logic [2:0]                      vsew_i,
    input  vlane_cfg_pkg::lane_cnt_t        inst_delay_i,
    input  vlane_cfg_pkg::el_width_t        wdata_width_i,
    input  vlane_cfg_pkg::vrf_addr_t        vrf_starting_waddr_i,
    input  vlane_cfg_pkg::vrf_addr_t [2:0]  vrf_starting_raddr_i,
    input  logic                            vrf_ren_i,
    input  driver_ctrl_pkg::alu_ctrl_t      alu_i,
    input  driver_ctrl_pkg::store_ctrl_t    store_sel_i,
    // Load source
    input  logic                            load_valid_i,
    input  logic                            load_last_i,
    output logic                            ready_for_load_o,
    // Address generation
    output driver_ctrl_pkg::wr_ctrl_t       wr_o,
    output logic                            rd_load_o,
    output logic                            rd_advance_o,
    output vlane_cfg_pkg::el_width_t        rd_width_o,
    output vlane_cfg_pkg::vrf_addr_t [2:0]  rd_start_o,
    // Side-band
    output logic                            vrf_ren_o,
    output vlane_cfg_pkg::lane_cnt_t        vmrf_addr_o,
    output logic                            vmrf_wen_o,
    output driver_ctrl_pkg::alu_ctrl_t      alu_o,
    output driver_ctrl_pkg::store_ctrl_t    store_o,
    output logic [1:0]                      write_data_sel_o,
    output logic [1:0]                      vsew_o
);
    import vlane_cfg_pkg::*;
    import driver_ctrl_pkg::*;

    drv_state_e      state;
    drv_state_e      next_state;
    // Instruction register
    inst_type_e      inst_type_q;
    lane_cnt_t       read_limit_q;
    lane_cnt_t       inst_delay_q;
    el_width_t       wdata_width_q;
    vrf_addr_t       waddr_start_q;
    vrf_addr_t [2:0] raddr_start_q;
    logic [1:0]      sew_q;
    alu_ctrl_t       alu_q;
    store_ctrl_t     store_sel_q;
    // Sequencing
    lane_cnt_t       read_limit;
    lane_cnt_t       main_cnt;
    lane_cnt_t       vmrf_cnt;
    logic            accept;
    logic            launch;
    logic            load_beat;
    logic            wr_active;
    logic            data_valid;
    logic            index_valid;
    logic [1:0]      write_data_sel;
    logic            vrf_ren_q;

    assign accept    = start_i & ready_o;
    assign launch    = (state == IDLE) && (next_state != IDLE);
    assign load_beat = (state == LOAD_MODE) & load_valid_i;

    // Elements per lane, rounded up
    assign read_limit = lane_cnt_t'(vl_i >> $clog2(VLANE_NUM))
                      + lane_cnt_t'(vl_i[$clog2(VLANE_NUM)-1:0] != '0);

    ////////////////////////////////////////////////////////////
    // Instruction register
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk_i) begin
        if (accept) begin
            inst_type_q   <= inst_type_i;
            read_limit_q  <= read_limit;
            inst_delay_q  <= inst_delay_i;
            wdata_width_q <= wdata_width_i;
            waddr_start_q <= vrf_starting_waddr_i;
            raddr_start_q <= vrf_starting_raddr_i;
            sew_q         <= vsew_i[1:0];
            alu_q         <= alu_i;
            store_sel_q   <= store_sel_i;  // Only the mux selects are used
        end
    end

    ////////////////////////////////////////////////////////////
    // Sequencing FSM
    ////////////////////////////////////////////////////////////
    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (!ready_o) begin  // Instruction latched last edge
                    case (inst_type_q)
                        NORMAL:  next_state = NORMAL_MODE;
                        LOAD:    next_state = LOAD_MODE;
                        default: next_state = READ_MODE;
                    endcase
                end
            end
            NORMAL_MODE: begin
                if (main_cnt == lane_cnt_t'(inst_delay_q + read_limit_q)) begin
                    next_state = IDLE;
                end
            end
            READ_MODE: begin
                if (main_cnt == read_limit_q - 1'b1) begin
                    next_state = IDLE;
                end
            end
            LOAD_MODE: begin
                if (load_last_i) begin
                    next_state = IDLE;
                end
            end
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            state          <= IDLE;
            ready_o        <= 1'b1;
            main_cnt       <= '0;
            vmrf_cnt       <= '0;
            wr_active      <= 1'b0;
            data_valid     <= 1'b0;
            index_valid    <= 1'b0;
            write_data_sel <= 2'd0;
            vrf_ren_q      <= 1'b0;
        end else begin
            state     <= next_state;
            vrf_ren_q <= vrf_ren_i;

            if (accept) begin
                ready_o <= 1'b0;
            end else if (state != IDLE && next_state == IDLE) begin
                ready_o <= 1'b1;
            end

            if (state == IDLE) begin
                main_cnt <= '0;
                vmrf_cnt <= '0;
            end else begin
                if (state != LOAD_MODE) main_cnt <= main_cnt + 1'b1;
                if (wr_active) vmrf_cnt <= vmrf_cnt + 1'b1;
            end

            // Write back opens once the pipeline delay has passed
            if (state == NORMAL_MODE && next_state == IDLE) begin
                wr_active <= 1'b0;
            end else if (state == NORMAL_MODE && main_cnt == inst_delay_q - 1'b1) begin
                wr_active <= 1'b1;
            end

            if (launch) begin
                data_valid     <= (inst_type_q == STORE) || (inst_type_q == INDEXED_STORE);
                index_valid    <= (inst_type_q == INDEXED_STORE)
                               || (inst_type_q == INDEXED_LOAD);
                write_data_sel <= (inst_type_q == LOAD) ? 2'd1 : 2'd0;
            end else if (next_state == IDLE) begin
                data_valid  <= 1'b0;
                index_valid <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Outputs
    ////////////////////////////////////////////////////////////
    assign wr_o = '{
        load_addr:  (state == IDLE),
        start_addr: waddr_start_q,
        advance:    wr_active | load_beat,
        width:      (state == LOAD_MODE) ? EW_WORD : wdata_width_q,
        bwen_en:    wr_active,
        load_mode:  load_beat
    };

    assign rd_load_o    = (state == IDLE);
    assign rd_advance_o = (state == NORMAL_MODE) || (state == READ_MODE);
    assign rd_start_o   = raddr_start_q;
    // vsew 0 and 1 read bytes and halfwords, wider reads whole words
    assign rd_width_o   = sew_q[1] ? EW_WORD : el_width_t'(sew_q + 2'd1);

    assign ready_for_load_o = (state == LOAD_MODE);
    assign vrf_ren_o        = vrf_ren_q;
    assign vmrf_addr_o      = vmrf_cnt;
    assign vmrf_wen_o       = wr_active & alu_q.vector_mask;
    assign alu_o            = alu_q;
    assign store_o = '{
        data_mux_sel:  store_sel_q.data_mux_sel,
        index_mux_sel: store_sel_q.index_mux_sel,
        data_valid:    data_valid,
        index_valid:   index_valid
    };
    assign write_data_sel_o = write_data_sel;
    assign vsew_o           = sew_q;

endmodule

`default_nettype wire

/* rtl/sublane_driver_top.sv */
`default_nettype none

module sublane_driver_top (
    input  logic                            clk_i,
    input  logic                            rst_i,
    // Handshake
    input  logic                            start_i,
    output logic                            ready_o,
    // Instruction fields
    input  driver_ctrl_pkg::inst_type_e     inst_type_i,
    input  vlane_cfg_pkg::vl_t              vl_i,
    input  logic [2:0]                      vsew_i,
    input  vlane_cfg_pkg::lane_cnt_t        inst_delay_i,
    input  vlane_cfg_pkg::el_width_t        wdata_width_i,
    input  vlane_cfg_pkg::vrf_addr_t        vrf_starting_waddr_i,
    input  vlane_cfg_pkg::vrf_addr_t [2:0]  vrf_starting_raddr_i,
    input  logic                            vrf_ren_i,
    input  driver_ctrl_pkg::alu_ctrl_t      alu_i,
    input  driver_ctrl_pkg::store_ctrl_t    store_sel_i,
    // Load source
    input  logic                            load_valid_i,
    input  logic                            load_last_i,
    input  vlane_cfg_pkg::lane_bwen_t       load_bwen_i,
    output logic                            ready_for_load_o,
    // VRF and VMRF
    output logic                            vrf_ren_o,
    output vlane_cfg_pkg::lane_addr_t       vrf_waddr_o,
    output vlane_cfg_pkg::vrf_addr_t [2:0]  vrf_raddr_o,  // vs1, vs2, vs3
    output vlane_cfg_pkg::lane_bwen_t       vrf_bwen_o,
    output vlane_cfg_pkg::lane_cnt_t        vmrf_addr_o,
    output logic                            vmrf_wen_o,
    // Side-band
    output driver_ctrl_pkg::alu_ctrl_t      alu_o,
    output driver_ctrl_pkg::store_ctrl_t    store_o,
    output logic [1:0]                      write_data_sel_o,
    output logic [1:0]                      vsew_o
);
    import vlane_cfg_pkg::*;
    import driver_ctrl_pkg::*;

    wr_ctrl_t        wr;
    logic            rd_load;
    logic            rd_advance;
    el_width_t       rd_width;
    vrf_addr_t [2:0] rd_start;

    driver_fsm u_fsm (
        .clk_i                (clk_i),
        .rst_i                (rst_i),
        .start_i              (start_i),
        .ready_o              (ready_o),
        .inst_type_i          (inst_type_i),
        .vl_i                 (vl_i),
        .vsew_i               (vsew_i),
        .inst_delay_i         (inst_delay_i),
        .wdata_width_i        (wdata_width_i),
        .vrf_starting_waddr_i (vrf_starting_waddr_i),
        .vrf_starting_raddr_i (vrf_starting_raddr_i),
        .vrf_ren_i            (vrf_ren_i),
        .alu_i                (alu_i),
        .store_sel_i          (store_sel_i),
        .load_valid_i         (load_valid_i),
        .load_last_i          (load_last_i),
        .ready_for_load_o     (ready_for_load_o),
        .wr_o                 (wr),
        .rd_load_o            (rd_load),
        .rd_advance_o         (rd_advance),
        .rd_width_o           (rd_width),
        .rd_start_o           (rd_start),
        .vrf_ren_o            (vrf_ren_o),
        .vmrf_addr_o          (vmrf_addr_o),
        .vmrf_wen_o           (vmrf_wen_o),
        .alu_o                (alu_o),
        .store_o              (store_o),
        .write_data_sel_o     (write_data_sel_o),
        .vsew_o               (vsew_o)
    );

    vrf_write_port u_write_port (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .wr_i        (wr),
        .load_bwen_i (load_bwen_i),
        .waddr_o     (vrf_waddr_o),
        .bwen_o      (vrf_bwen_o)
    );

    // One read counter per source operand
    for (genvar src = 0; src < 3; src++) begin : g_raddr
        vrf_addr_counter u_raddr_cnt (
            .clk_i        (clk_i),
            .rst_i        (rst_i),
            .load_i       (rd_load),
            .start_addr_i (rd_start[src]),
            .advance_i    (rd_advance),
            .width_i      (rd_width),
            .addr_o       (vrf_raddr_o[src]),
            .beat_o       ()
        );
    end

endmodule

`default_nettype wire

/* tests/sublane_driver_assertions.sv */
`default_nettype none

module sublane_driver_assertions (
    input logic                          clk_i,
    input logic                          rst_i,
    input logic                          start_i,
    input logic                          ready_o,
    input logic                          load_valid_i,
    input logic                          load_last_i,
    input vlane_cfg_pkg::lane_bwen_t     load_bwen_i,
    input logic                          ready_for_load_o,
    input vlane_cfg_pkg::lane_bwen_t     vrf_bwen_o,
    input logic                          vmrf_wen_o,
    input driver_ctrl_pkg::alu_ctrl_t    alu_i,
    input driver_ctrl_pkg::alu_ctrl_t    alu_o,
    input driver_ctrl_pkg::store_ctrl_t  store_sel_i,
    input driver_ctrl_pkg::store_ctrl_t  store_o
);

    int fail_cnt = 0;  // Assertion failures so far

    ////////////////////////////////////////////////////////////
    // Reset and handshake
    ////////////////////////////////////////////////////////////
    assert property (@(posedge clk_i) !rst_i |=> ready_o && !vmrf_wen_o && !ready_for_load_o
                     && !store_o.data_valid && !store_o.index_valid && vrf_bwen_o == '0)
    else begin
        fail_cnt++;
        $error("Outputs not idle after a reset cycle");
    end

    assert property (@(posedge clk_i) disable iff (!rst_i) start_i && ready_o |=> !ready_o)
    else begin
        fail_cnt++;
        $error("ready_o still high after an accepted start");
    end

    // Side-band captured at accept, then frozen while busy
    assert property (@(posedge clk_i) disable iff (!rst_i)
                     start_i && ready_o |=> alu_o == $past(alu_i)
                     && store_o.data_mux_sel == $past(store_sel_i.data_mux_sel)
                     && store_o.index_mux_sel == $past(store_sel_i.index_mux_sel))
    else begin
        fail_cnt++;
        $error("Side-band outputs differ from the accepted fields");
    end

    assert property (@(posedge clk_i) disable iff (!rst_i)
                     !ready_o |=> $stable(alu_o) && $stable(store_o.data_mux_sel)
                     && $stable(store_o.index_mux_sel))
    else begin
        fail_cnt++;
        $error("Side-band outputs changed during an instruction");
    end

    ////////////////////////////////////////////////////////////
    // Load mode
    ////////////////////////////////////////////////////////////
    assert property (@(posedge clk_i) disable iff (!rst_i)
                     ready_for_load_o && !load_last_i |=> ready_for_load_o)
    else begin
        fail_cnt++;
        $error("ready_for_load_o dropped before load_last_i");
    end

    assert property (@(posedge clk_i) disable iff (!rst_i)
                     ready_for_load_o && load_last_i |=> !ready_for_load_o)
    else begin
        fail_cnt++;
        $error("ready_for_load_o still high after load_last_i");
    end

    assert property (@(posedge clk_i) disable iff (!rst_i)
                     ready_for_load_o |-> vrf_bwen_o == (load_valid_i ? load_bwen_i : '0))
    else begin
        fail_cnt++;
        $error("vrf_bwen_o does not follow the load source");
    end

    // Mask and store strobes only while an instruction is busy
    assert property (@(posedge clk_i) disable iff (!rst_i)
                     vmrf_wen_o || store_o.data_valid || store_o.index_valid |-> !ready_o)
    else begin
        fail_cnt++;
        $error("Strobe active outside its instruction");
    end

endmodule

bind sublane_driver_top sublane_driver_assertions u_assertions (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .start_i          (start_i),
    .ready_o          (ready_o),
    .load_valid_i     (load_valid_i),
    .load_last_i      (load_last_i),
    .load_bwen_i      (load_bwen_i),
    .ready_for_load_o (ready_for_load_o),
    .vrf_bwen_o       (vrf_bwen_o),
    .vmrf_wen_o       (vmrf_wen_o),
    .alu_i            (alu_i),
    .alu_o            (alu_o),
    .store_sel_i      (store_sel_i),
    .store_o          (store_o)
);

`default_nettype wire

/* tests/tb_sublane_driver.sv */
`default_nettype none

module tb_sublane_driver;
    import vlane_cfg_pkg::*;
    import driver_ctrl_pkg::*;

    logic            clk_i;
    logic            rst_i;
    logic            start_i;
    logic            ready_o;
    inst_type_e      inst_type_i;
    vl_t             vl_i;
    logic [2:0]      vsew_i;
    lane_cnt_t       inst_delay_i;
    el_width_t       wdata_width_i;
    vrf_addr_t       vrf_starting_waddr_i;
    vrf_addr_t [2:0] vrf_starting_raddr_i;
    logic            vrf_ren_i;
    alu_ctrl_t       alu_i;
    store_ctrl_t     store_sel_i;
    logic            load_valid_i;
    logic            load_last_i;
    lane_bwen_t      load_bwen_i;
    logic            ready_for_load_o;
    logic            vrf_ren_o;
    lane_addr_t      vrf_waddr_o;
    vrf_addr_t [2:0] vrf_raddr_o;
    lane_bwen_t      vrf_bwen_o;
    lane_cnt_t       vmrf_addr_o;
    logic            vmrf_wen_o;
    alu_ctrl_t       alu_o;
    store_ctrl_t     store_o;
    logic [1:0]      write_data_sel_o;
    logic [1:0]      vsew_o;

    integer     seed;
    int         err_cnt = 0;
    int         total;
    // Strobe cycle counts of the current instruction
    int         dv_cnt;
    int         iv_cnt;
    int         rd_cnt;
    int         wen_cnt;
    int         bw_cnt;
    int         ld_cnt;
    // Expectations of the current instruction
    inst_type_e cur_type;
    int         cur_rl;
    logic       cur_mask;
    el_width_t  cur_width;
    int         cur_words;
    logic       cur_ren;
    vrf_addr_t [2:0] exp_raddr;
    vrf_addr_t  exp_waddr;
    alu_ctrl_t  exp_alu;

    sublane_driver_top dut (.*);

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
        if (exp !== act) begin
            err_cnt++;
            $display("ERR %0t %s expected %0h actual %0h", $time, name, exp, act);
        end
    endtask

    task automatic abort_on_timeout(input string what);
        $display("Timeout: %s within the allowed cycles", what);
        $display("Summary: %0d value errors, %0d assertion failures",
                 err_cnt, dut.u_assertions.fail_cnt);
        $display("Test failures found");
        $finish;
    endtask

    function automatic bwen_t expected_pattern(input el_width_t w, input int beat);
        case (w)
            EW_BYTE: return bwen_t'(4'b0001 << (beat % 4));
            EW_HALF: return (beat % 2) ? 4'b1100 : 4'b0011;
            EW_WORD: return 4'b1111;
            default: return 4'b0000;
        endcase
    endfunction

    function automatic vl_t random_vl();
        return vl_t'(1 + {$random(seed)} % 2047);
    endfunction

    ////////////////////////////////////////////////////////////
    // Per-cycle monitor, sampled mid-cycle
    ////////////////////////////////////////////////////////////
    always @(negedge clk_i) begin
        if (rst_i) begin
            if (store_o.data_valid || store_o.index_valid) begin
                for (int src = 0; src < 3; src++) begin
                    check_value($sformatf("vrf_raddr_o[%0d]", src),
                                vrf_addr_t'(exp_raddr[src] + rd_cnt), vrf_raddr_o[src]);
                end
                rd_cnt++;
            end
            if (store_o.data_valid) dv_cnt++;
            if (store_o.index_valid) iv_cnt++;
            if (vmrf_wen_o) begin
                check_value("vmrf_addr_o", wen_cnt, vmrf_addr_o);
                wen_cnt++;
            end
            if (ready_for_load_o && load_valid_i) begin
                for (int lane = 0; lane < VLANE_NUM; lane++) begin
                    check_value($sformatf("vrf_waddr_o[%0d]", lane),
                                vrf_addr_t'(exp_waddr + ld_cnt), vrf_waddr_o[lane]);
                end
                ld_cnt++;
            end else if (!ready_for_load_o && vrf_bwen_o != '0) begin
                for (int lane = 0; lane < VLANE_NUM; lane++) begin
                    check_value($sformatf("vrf_bwen_o[%0d]", lane),
                                expected_pattern(cur_width, bw_cnt), vrf_bwen_o[lane]);
                end
                bw_cnt++;  // Write beat index
            end
        end
    end

    task automatic wait_ready();
        int cycles;
        cycles = 0;
        @(negedge clk_i);
        while (!ready_o) begin
            if (cycles == 1000) begin
                abort_on_timeout("ready_o did not return high");
            end else begin
                @(negedge clk_i);
                cycles++;
            end
        end
    endtask

    task automatic wait_load_ready();
        int cycles;
        cycles = 0;
        @(negedge clk_i);
        while (!ready_for_load_o) begin
            if (cycles == 100) begin
                abort_on_timeout("ready_for_load_o did not rise");
            end else begin
                @(negedge clk_i);
                cycles++;
            end
        end
    endtask

    task automatic run_instruction(input inst_type_e t, input vl_t vl, input lane_cnt_t delay,
                                   input el_width_t w, input logic mask, input int words);
        alu_ctrl_t alu;
        int        sent;
        int        idle;
        logic      valid;
        wait_ready();
        alu = alu_ctrl_t'({$random(seed), $random(seed)});
        alu.vector_mask = mask;
        @(posedge clk_i);
        cur_type  = t;
        cur_rl    = (int'(vl) + VLANE_NUM - 1) / VLANE_NUM;  // Per-lane count rounded up
        cur_mask  = mask;
        cur_width = w;
        cur_words = words;
        cur_ren   = ($random(seed) & 1) != 0;
        exp_raddr = {vrf_addr_t'($random(seed)), vrf_addr_t'($random(seed)),
                     vrf_addr_t'($random(seed))};
        exp_waddr = vrf_addr_t'($random(seed));
        exp_alu   = alu;
        dv_cnt    = 0;
        iv_cnt    = 0;
        rd_cnt    = 0;
        wen_cnt   = 0;
        bw_cnt    = 0;
        ld_cnt    = 0;
        inst_type_i          <= t;
        vl_i                 <= vl;
        inst_delay_i         <= delay;
        wdata_width_i        <= w;
        vrf_starting_waddr_i <= exp_waddr;
        vrf_starting_raddr_i <= exp_raddr;
        vrf_ren_i            <= cur_ren;
        alu_i                <= alu;
        store_sel_i          <= store_ctrl_t'($random(seed));
        start_i              <= 1'b1;
        @(posedge clk_i);  // Accept edge
        start_i     <= 1'b0;
        // Fresh side-band that the busy DUT has to ignore
        alu_i       <= alu_ctrl_t'({$random(seed), $random(seed)});
        store_sel_i <= store_ctrl_t'($random(seed));

        if (t == LOAD) begin
            wait_load_ready();
            sent = 0;
            idle = 0;
            while (sent < words) begin
                @(posedge clk_i);
                valid = (($random(seed) & 3) != 0) || (idle == 2);
                load_valid_i <= valid;
                load_bwen_i  <= lane_bwen_t'($random(seed));
                load_last_i  <= valid && (sent == words - 1);
                if (valid) begin
                    sent++;
                    idle = 0;
                end else begin
                    idle++;
                end
            end
            @(posedge clk_i);
            load_valid_i <= 1'b0;
            load_last_i  <= 1'b0;
        end

        wait_ready();
        case (cur_type)
            NORMAL: begin
                check_value("vmrf_wen_o cycles", cur_mask ? cur_rl + 1 : 0, wen_cnt);
                check_value("vrf_bwen_o cycles", (cur_width == EW_NONE) ? 0 : cur_rl + 1, bw_cnt);
            end
            LOAD: check_value("load words written", cur_words, ld_cnt);
            default: begin
                check_value("store_data_valid_o cycles",
                            (cur_type == INDEXED_LOAD) ? 0 : cur_rl, dv_cnt);
                check_value("store_index_valid_o cycles", (cur_type == STORE) ? 0 : cur_rl, iv_cnt);
            end
        endcase
        check_value("alu_o", exp_alu, alu_o);
        check_value("vsew_o", vsew_i[1:0], vsew_o);
        check_value("vrf_ren_o", cur_ren, vrf_ren_o);
        check_value("write_data_sel_o", (cur_type == LOAD) ? 2'd1 : 2'd0, write_data_sel_o);
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////
    initial begin
        seed                 = 32'h0e22_9de8;
        rst_i                = 1'b0;
        start_i              = 1'b0;
        inst_type_i          = NORMAL;
        vl_i                 = '0;
        vsew_i               = 3'd2;  // Word reads
        inst_delay_i         = '0;
        wdata_width_i        = EW_NONE;
        vrf_starting_waddr_i = '0;
        vrf_starting_raddr_i = '0;
        vrf_ren_i            = 1'b0;
        alu_i                = '0;
        store_sel_i          = '0;
        load_valid_i         = 1'b0;
        load_last_i          = 1'b0;
        load_bwen_i          = '0;
        repeat (5) @(posedge clk_i);
        rst_i <= 1'b1;

        @(negedge clk_i);
        check_value("ready_o", 1, ready_o);
        check_value("vmrf_wen_o", 0, vmrf_wen_o);
        check_value("ready_for_load_o", 0, ready_for_load_o);
        check_value("store_o.data_valid", 0, store_o.data_valid);
        check_value("store_o.index_valid", 0, store_o.index_valid);
        check_value("vrf_bwen_o", 0, vrf_bwen_o);

        for (int i = 0; i < 3; i++) begin
            run_instruction(STORE, random_vl(), 1, EW_WORD, 1'b0, 0);
            run_instruction(INDEXED_STORE, random_vl(), 1, EW_WORD, 1'b0, 0);
            run_instruction(INDEXED_LOAD, random_vl(), 1, EW_WORD, 1'b0, 0);
        end
        for (int w = 0; w < 4; w++) begin
            run_instruction(NORMAL, random_vl(), lane_cnt_t'(1 + {$random(seed)} % 8),
                            el_width_t'(w), 1'b1, 0);
            run_instruction(NORMAL, random_vl(), lane_cnt_t'(1 + {$random(seed)} % 8),
                            el_width_t'(w), 1'b0, 0);
        end
        for (int i = 0; i < 4; i++) begin
            run_instruction(LOAD, random_vl(), 1, EW_WORD, 1'b0, 1 + {$random(seed)} % 20);
        end
        wait_ready();

        total = err_cnt + dut.u_assertions.fail_cnt;
        $display("Summary: %0d value errors, %0d assertion failures",
                 err_cnt, dut.u_assertions.fail_cnt);
        if (total == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
rtl/vlane_cfg_pkg.sv
rtl/driver_ctrl_pkg.sv
rtl/vrf_addr_counter.sv
rtl/vrf_write_port.sv
rtl/driver_fsm.sv
rtl/sublane_driver_top.sv
tests/sublane_driver_assertions.sv
tests/tb_sublane_driver.sv
